//--- sources.f
+incdir+.
mesh_pkt_pkg.sv
mesh_dir_pkg.sv
rr_arbiter.sv
mesh_router.sv
tile_endpoint.sv
compute_tile.sv
tile_array_ruche.sv
tb_tile_array.sv

//--- run.sh
#!/bin/sh
# compile and run the tile row testbench with Verilator
# exits nonzero if the build, the run or any check fails

cd "$(dirname "$0")" || exit 1

build_log=build.log
sim_log=sim.log

verilator --binary --timing -j 0 --top-module tb_tile_array \
  -f sources.f -o tb_tile_array > "$build_log" 2>&1
status=$?
if [ $status -ne 0 ]; then
  cat "$build_log"
  echo "verilator build failed with status $status"
  exit 1
fi

./obj_dir/tb_tile_array > "$sim_log" 2>&1
status=$?
cat "$sim_log"

if grep -q "Regression failed" "$sim_log"; then
  exit 1
fi
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi
exit 0

//--- tb_tile_array.sv
// testbench for the ruche tile row with stores, loads, back-pressure, barrier and x chain
// replies are checked against a shadow memory per tile and address
`timescale 1ns/1ps
`default_nettype none

`include "mesh_params.svh"

module tb_tile_array;

  localparam int N      = `MESH_NUM_TILES;
  localparam int PKT_W  = mesh_pkt_pkg::pkt_w;
  localparam int DATA_W = `MESH_DATA_W;
  localparam int ADDR_W = `MESH_ADDR_W;
  localparam int X_W    = `MESH_X_W;

  logic                  clk;
  logic                  arst_n;
  logic [PKT_W-1:0]      host_pkt_i;
  logic                  host_valid_i;
  logic                  host_ready_o;
  logic [PKT_W-1:0]      host_pkt_o;
  logic                  host_valid_o;
  logic                  host_ready_i;
  logic [N-1:0]          barrier_req_i;
  logic                  barrier_done_o;
  mesh_pkt_pkg::x_cord_t global_x_i;
  mesh_pkt_pkg::x_cord_t global_x_o;

  // stimulus table with one entry per row
  logic [1:0] op_q[$];
  int         dst_q[$];
  int         addr_q[$];
  int         data_q[$];
  string      name_q[$];

  // expected replies per tile with addr in the upper half and data below
  int    exp_q[1:N][$];
  string exp_name_q[1:N][$];
  int    shadow[1:N][0:(1<<ADDR_W)-1];

  int          seed = 32'h1231;
  logic [31:0] rnd;
  logic        bp_en;
  int          cycle_cnt;
  int          limit;
  int          loads, replies;
  int          ruche_cnt, exp_ruche, east_cnt, exp_east;
  int          mon_src, mon_key;
  string       mon_name;

  tile_array_ruche i_dut (
    .clk_i          (clk),
    .arst_n_i       (arst_n),
    .host_pkt_i     (host_pkt_i),
    .host_valid_i   (host_valid_i),
    .host_ready_o   (host_ready_o),
    .host_pkt_o     (host_pkt_o),
    .host_valid_o   (host_valid_o),
    .host_ready_i   (host_ready_i),
    .barrier_req_i  (barrier_req_i),
    .barrier_done_o (barrier_done_o),
    .global_x_i     (global_x_i),
    .global_x_o     (global_x_o)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic check_value(input string name, input int expected, input int actual);
    if (expected != actual) begin
      $display("Error: %s expected %0h actual %0h", name, expected, actual);
      $display("Regression failed");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic add_row(input logic [1:0] op, input int dst, input int addr,
                         input int data, input string name);
    op_q.push_back(op);
    dst_q.push_back(dst);
    addr_q.push_back(addr);
    data_q.push_back(data);
    name_q.push_back(name);
  endtask

  // field order opcode, dst_x, src_x, addr, data from msb down
  function automatic logic [PKT_W-1:0] make_pkt(input logic [1:0] op, input int dst,
                                                input int addr, input int data);
    logic [X_W-1:0]    dst_f;
    logic [ADDR_W-1:0] addr_f;
    logic [DATA_W-1:0] data_f;
    dst_f  = dst[X_W-1:0];
    addr_f = addr[ADDR_W-1:0];
    data_f = data[DATA_W-1:0];
    return {op, dst_f, {X_W{1'b0}}, addr_f, data_f};
  endfunction

  task automatic step(input int n);
    repeat (n) @(posedge clk);
    #2;
  endtask

  // run limit from the table length
  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt > limit) begin
      $display("Timeout: run did not finish within %0d cycles", limit);
      $display("Regression failed");
      $fatal(1, "timeout");
    end
  end

  // random host back-pressure
  always @(posedge clk) begin
    #2;
    if (bp_en) begin
      rnd = $random(seed);
      host_ready_i = rnd[0];
    end
  end

  // reply monitor sampled mid-cycle before the transfer edge
  always @(negedge clk) begin
    if (arst_n && host_valid_o && host_ready_i) begin
      mon_src = int'(host_pkt_o[DATA_W+ADDR_W +: X_W]);
      check_value("reply opcode", mesh_pkt_pkg::OP_REPLY, int'(host_pkt_o[PKT_W-1 -: 2]));
      check_value("reply dst_x", 0, int'(host_pkt_o[DATA_W+ADDR_W+X_W +: X_W]));
      if (mon_src < 1 || mon_src > N || exp_q[mon_src].size() == 0) begin
        $display("Reply from tile %0d arrived with no load outstanding", mon_src);
        $display("Regression failed");
        $fatal(1, "unexpected reply");
      end
      mon_key  = exp_q[mon_src].pop_front();
      mon_name = exp_name_q[mon_src].pop_front();
      check_value(mon_name, mon_key >>> 16, int'(host_pkt_o[DATA_W +: ADDR_W]));
      check_value(mon_name, mon_key & 32'hffff, int'(host_pkt_o[DATA_W-1:0]));
      replies++;
    end
    // tile 1 east and ruche east transfers
    if (i_dut.re_v_lo[0] && i_dut.re_r_li[0]) begin
      ruche_cnt++;
    end
    if (i_dut.e_v_lo[0] && i_dut.e_r_li[0]) begin
      east_cnt++;
    end
  end

  initial begin
    arst_n        = 1'b0;
    host_pkt_i    = '0;
    host_valid_i  = 1'b0;
    host_ready_i  = 1'b1;
    barrier_req_i = '0;
    global_x_i    = '0;
    bp_en         = 1'b0;
    cycle_cnt     = 0;
    foreach (shadow[t, a]) begin
      shadow[t][a] = 0;
    end

    add_row(mesh_pkt_pkg::OP_STORE, 1, 3, 16'h1111, "store tile 1");
    add_row(mesh_pkt_pkg::OP_STORE, 2, 5, 16'h2222, "store tile 2");
    add_row(mesh_pkt_pkg::OP_STORE, 3, 7, 16'h3333, "store tile 3");
    add_row(mesh_pkt_pkg::OP_STORE, 4, 9, 16'h4444, "store tile 4");
    add_row(mesh_pkt_pkg::OP_STORE, 4, 0, 16'h4a4a, "store tile 4 word 0");
    add_row(mesh_pkt_pkg::OP_STORE, 3, 15, 16'h3c3c, "store tile 3 word 15");
    add_row(mesh_pkt_pkg::OP_STORE, 1, 3, 16'h1212, "overwrite tile 1");
    add_row(mesh_pkt_pkg::OP_LOAD, 1, 3, 0, "load tile 1");
    add_row(mesh_pkt_pkg::OP_LOAD, 2, 5, 0, "load tile 2");
    add_row(mesh_pkt_pkg::OP_LOAD, 3, 7, 0, "load tile 3 ruche");
    add_row(mesh_pkt_pkg::OP_LOAD, 4, 9, 0, "load tile 4 ruche");
    add_row(mesh_pkt_pkg::OP_LOAD, 4, 0, 0, "load tile 4 word 0");
    add_row(mesh_pkt_pkg::OP_LOAD, 3, 15, 0, "load tile 3 word 15");
    add_row(mesh_pkt_pkg::OP_LOAD, 1, 8, 0, "unwritten tile 1");
    add_row(mesh_pkt_pkg::OP_LOAD, 2, 0, 0, "unwritten tile 2");
    add_row(mesh_pkt_pkg::OP_LOAD, 3, 1, 0, "unwritten tile 3");
    add_row(mesh_pkt_pkg::OP_LOAD, 4, 14, 0, "unwritten tile 4");
    for (int t = 1; t <= N; t++) begin
      add_row(mesh_pkt_pkg::OP_STORE, t, 10, 16'h0a00 + t, "burst store");
    end
    // alternate addresses so reordering would show up in the data
    for (int rep = 0; rep < 3; rep++) begin
      for (int t = N; t >= 1; t--) begin
        add_row(mesh_pkt_pkg::OP_LOAD, t, (rep % 2 == 0) ? 10 : 2 * t + 1,
                0, $sformatf("burst load %0d tile %0d", rep, t));
      end
    end
    limit = 40 * op_q.size() + 200;

    step(4);
    arst_n = 1'b1;

    // x coordinate chain and idle outputs after reset
    for (int n = 1; n <= N; n++) begin
      step(1);
      check_value("idle barrier after reset", 0, int'(barrier_done_o));
      check_value("idle host reply after reset", 0, int'(host_valid_o));
    end
    check_value("global x after reset", N, int'(global_x_o));
    global_x_i = 3'd3;
    step(N);
    check_value("global x with offset 3", 3 + N, int'(global_x_o));
    global_x_i = '0;
    step(N);
    check_value("global x back to 0", N, int'(global_x_o));

    // traffic under random host back-pressure
    bp_en = 1'b1;
    for (int r = 0; r < op_q.size(); r++) begin
      logic accepted;
      host_pkt_i   = make_pkt(op_q[r], dst_q[r], addr_q[r], data_q[r]);
      host_valid_i = 1'b1;
      if (op_q[r] == mesh_pkt_pkg::OP_STORE) begin
        shadow[dst_q[r]][addr_q[r]] = data_q[r];
      end else begin
        exp_q[dst_q[r]].push_back((addr_q[r] << 16) | shadow[dst_q[r]][addr_q[r]]);
        exp_name_q[dst_q[r]].push_back(name_q[r]);
        loads++;
      end
      // ruche hop leaves tile 1 once the distance reaches the ruche factor
      if (dst_q[r] - 1 >= `MESH_RUCHE_FACTOR) begin
        exp_ruche++;
      end else if (dst_q[r] == 2) begin
        exp_east++;
      end
      accepted = 1'b0;
      while (!accepted) begin
        @(negedge clk);
        accepted = host_ready_o;
        step(1);
      end
      host_valid_i = 1'b0;
    end
    while (replies != loads) begin
      @(posedge clk);
    end
    #2;
    bp_en        = 1'b0;
    host_ready_i = 1'b1;
    step(4);
    check_value("ruche east transfers from tile 1", exp_ruche, ruche_cnt);
    check_value("local east transfers from tile 1", exp_east, east_cnt);

    // barrier rises and falls one tile per cycle along the chain
    barrier_req_i = '1;
    for (int k = 0; k <= N; k++) begin
      @(negedge clk);
      check_value($sformatf("barrier rise cycle %0d", k), (k >= N) ? 1 : 0,
                  int'(barrier_done_o));
    end
    step(1);
    barrier_req_i[0] = 1'b0;
    for (int k = 0; k <= N; k++) begin
      @(negedge clk);
      check_value($sformatf("barrier fall cycle %0d", k), (k < N) ? 1 : 0,
                  int'(barrier_done_o));
    end

    $display("Regression passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- tile_array_ruche.sv
// top level: a row of compute tiles joined by local and half-ruche x links
// host attaches on the west local edge of tile 1, other edges are tied idle
`timescale 1ns/1ps
`default_nettype none

`include "mesh_params.svh"

module tile_array_ruche (
  input  wire logic                           clk_i,
  input  wire logic                           arst_n_i,
  input  wire logic [mesh_pkt_pkg::pkt_w-1:0] host_pkt_i,
  input  wire logic                           host_valid_i,
  output logic                                host_ready_o,
  output logic      [mesh_pkt_pkg::pkt_w-1:0] host_pkt_o,
  output logic                                host_valid_o,
  input  wire logic                           host_ready_i,
  input  wire logic [`MESH_NUM_TILES-1:0]     barrier_req_i,
  output logic                                barrier_done_o,
  input  wire mesh_pkt_pkg::x_cord_t          global_x_i,
  output mesh_pkt_pkg::x_cord_t               global_x_o
);

  localparam int N     = `MESH_NUM_TILES;
  localparam int RF    = `MESH_RUCHE_FACTOR;
  localparam int PKT_W = mesh_pkt_pkg::pkt_w;

  // _li into a tile, _lo out of a tile
  logic [N-1:0][PKT_W-1:0] w_pkt_li, w_pkt_lo, e_pkt_li, e_pkt_lo;
  logic [N-1:0][PKT_W-1:0] rw_pkt_li, rw_pkt_lo, re_pkt_li, re_pkt_lo;
  logic [N-1:0] w_v_li, w_v_lo, w_r_li, w_r_lo, e_v_li, e_v_lo, e_r_li, e_r_lo;
  logic [N-1:0] rw_v_li, rw_v_lo, rw_r_li, rw_r_lo, re_v_li, re_v_lo, re_r_li, re_r_lo;
  logic [N:0]   chain;
  mesh_pkt_pkg::x_cord_t [N:0] gx;

  assign chain[0] = 1'b1;
  assign gx[0]    = global_x_i;

  for (genvar c = 0; c < N; c++) begin : g_tile
    compute_tile #(.MY_X(c + 1)) i_tile (
      .clk_i (clk_i), .arst_n_i (arst_n_i),
      .w_pkt_i (w_pkt_li[c]), .w_valid_i (w_v_li[c]), .w_ready_o (w_r_lo[c]),
      .w_pkt_o (w_pkt_lo[c]), .w_valid_o (w_v_lo[c]), .w_ready_i (w_r_li[c]),
      .e_pkt_i (e_pkt_li[c]), .e_valid_i (e_v_li[c]), .e_ready_o (e_r_lo[c]),
      .e_pkt_o (e_pkt_lo[c]), .e_valid_o (e_v_lo[c]), .e_ready_i (e_r_li[c]),
      .rw_pkt_i (rw_pkt_li[c]), .rw_valid_i (rw_v_li[c]), .rw_ready_o (rw_r_lo[c]),
      .rw_pkt_o (rw_pkt_lo[c]), .rw_valid_o (rw_v_lo[c]), .rw_ready_i (rw_r_li[c]),
      .re_pkt_i (re_pkt_li[c]), .re_valid_i (re_v_li[c]), .re_ready_o (re_r_lo[c]),
      .re_pkt_o (re_pkt_lo[c]), .re_valid_o (re_v_lo[c]), .re_ready_i (re_r_li[c]),
      .barrier_req_i (barrier_req_i[c]),
      .barrier_chain_i (chain[c]), .barrier_chain_o (chain[c+1]),
      .global_x_i (gx[c]), .global_x_o (gx[c+1])
    );

    // local west side: host at the edge, else the neighbour's east
    if (c == 0) begin : g_w_host
      assign w_pkt_li[c] = host_pkt_i;
      assign w_v_li[c]   = host_valid_i;
      assign w_r_li[c]   = host_ready_i;
    end else begin : g_w_link
      assign w_pkt_li[c] = e_pkt_lo[c-1];
      assign w_v_li[c]   = e_v_lo[c-1];
      assign w_r_li[c]   = e_r_lo[c-1];
    end

    if (c == N - 1) begin : g_e_edge
      assign e_pkt_li[c] = '0;
      assign e_v_li[c]   = 1'b0;
      assign e_r_li[c]   = 1'b1;
    end else begin : g_e_link
      assign e_pkt_li[c] = w_pkt_lo[c+1];
      assign e_v_li[c]   = w_v_lo[c+1];
      assign e_r_li[c]   = w_r_lo[c+1];
    end

    // ruche spans RF tiles, edge ruche ports stay idle
    if (c < RF) begin : g_rw_edge
      assign rw_pkt_li[c] = '0;
      assign rw_v_li[c]   = 1'b0;
      assign rw_r_li[c]   = 1'b1;
    end else begin : g_rw_link
      assign rw_pkt_li[c] = re_pkt_lo[c-RF];
      assign rw_v_li[c]   = re_v_lo[c-RF];
      assign rw_r_li[c]   = re_r_lo[c-RF];
    end

    if (c + RF >= N) begin : g_re_edge
      assign re_pkt_li[c] = '0;
      assign re_v_li[c]   = 1'b0;
      assign re_r_li[c]   = 1'b1;
    end else begin : g_re_link
      assign re_pkt_li[c] = rw_pkt_lo[c+RF];
      assign re_v_li[c]   = rw_v_lo[c+RF];
      assign re_r_li[c]   = rw_r_lo[c+RF];
    end
  end

  assign host_ready_o   = w_r_lo[0];
  assign host_pkt_o     = w_pkt_lo[0];
  assign host_valid_o   = w_v_lo[0];
  assign barrier_done_o = chain[N];
  assign global_x_o     = gx[N];

endmodule

`default_nettype wire

//--- compute_tile.sv
// one tile of the row with router, memory endpoint, barrier stage and x coordinate
`timescale 1ns/1ps
`default_nettype none

module compute_tile #(
  parameter int MY_X = 1
) (
  input  wire logic                           clk_i,
  input  wire logic                           arst_n_i,
  input  wire logic [mesh_pkt_pkg::pkt_w-1:0] w_pkt_i,
  input  wire logic                           w_valid_i,
  output logic                                w_ready_o,
  output logic      [mesh_pkt_pkg::pkt_w-1:0] w_pkt_o,
  output logic                                w_valid_o,
  input  wire logic                           w_ready_i,
  input  wire logic [mesh_pkt_pkg::pkt_w-1:0] e_pkt_i,
  input  wire logic                           e_valid_i,
  output logic                                e_ready_o,
  output logic      [mesh_pkt_pkg::pkt_w-1:0] e_pkt_o,
  output logic                                e_valid_o,
  input  wire logic                           e_ready_i,
  input  wire logic [mesh_pkt_pkg::pkt_w-1:0] rw_pkt_i,
  input  wire logic                           rw_valid_i,
  output logic                                rw_ready_o,
  output logic      [mesh_pkt_pkg::pkt_w-1:0] rw_pkt_o,
  output logic                                rw_valid_o,
  input  wire logic                           rw_ready_i,
  input  wire logic [mesh_pkt_pkg::pkt_w-1:0] re_pkt_i,
  input  wire logic                           re_valid_i,
  output logic                                re_ready_o,
  output logic      [mesh_pkt_pkg::pkt_w-1:0] re_pkt_o,
  output logic                                re_valid_o,
  input  wire logic                           re_ready_i,
  input  wire logic                           barrier_req_i,
  input  wire logic                           barrier_chain_i,
  output logic                                barrier_chain_o,
  input  wire mesh_pkt_pkg::x_cord_t          global_x_i,
  output mesh_pkt_pkg::x_cord_t               global_x_o
);

  logic [mesh_dir_pkg::NUM_DIRS-1:0][mesh_pkt_pkg::pkt_w-1:0] pkt_li, pkt_lo;
  logic [mesh_dir_pkg::NUM_DIRS-1:0] valid_li, valid_lo, ready_li, ready_lo;
  logic [mesh_pkt_pkg::pkt_w-1:0] ep_pkt;
  logic ep_valid, ep_ready;
  mesh_pkt_pkg::x_cord_t global_x_q;
  logic                  barrier_q;

  // pack the loose links into router port order with the endpoint on P
  assign pkt_li   = {re_pkt_i, rw_pkt_i, e_pkt_i, w_pkt_i, ep_pkt};
  assign valid_li = {re_valid_i, rw_valid_i, e_valid_i, w_valid_i, ep_valid};
  assign ready_li = {re_ready_i, rw_ready_i, e_ready_i, w_ready_i, ep_ready};

  mesh_router #(.MY_X(MY_X)) i_router (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .link_pkt_i   (pkt_li),
    .link_valid_i (valid_li),
    .link_ready_o (ready_lo),
    .link_pkt_o   (pkt_lo),
    .link_valid_o (valid_lo),
    .link_ready_i (ready_li)
  );

  tile_endpoint i_endpoint (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .my_x_i      (global_x_q),
    .req_pkt_i   (pkt_lo[mesh_dir_pkg::DIR_P]),
    .req_valid_i (valid_lo[mesh_dir_pkg::DIR_P]),
    .req_ready_o (ep_ready),
    .rsp_pkt_o   (ep_pkt),
    .rsp_valid_o (ep_valid),
    .rsp_ready_i (ready_lo[mesh_dir_pkg::DIR_P])
  );

  assign {re_pkt_o, rw_pkt_o, e_pkt_o, w_pkt_o}         = pkt_lo[4:1];
  assign {re_valid_o, rw_valid_o, e_valid_o, w_valid_o} = valid_lo[4:1];
  assign {re_ready_o, rw_ready_o, e_ready_o, w_ready_o} = ready_lo[4:1];

  // barrier stage and coordinate step take one cycle per tile
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      barrier_q  <= 1'b0;
      global_x_q <= '0;
    end else begin
      barrier_q  <= barrier_req_i & barrier_chain_i;
      global_x_q <= global_x_i + 1'b1;
    end
  end

  assign barrier_chain_o = barrier_q;
  assign global_x_o      = global_x_q;

endmodule

`default_nettype wire

//--- tile_endpoint.sv
// word memory endpoint on the router P port
// stores write memory silently, loads return one reply packet to the host
`timescale 1ns/1ps
`default_nettype none

`include "mesh_params.svh"

module tile_endpoint (
  input  wire logic                           clk_i,
  input  wire logic                           arst_n_i,
  input  wire mesh_pkt_pkg::x_cord_t          my_x_i,
  input  wire logic [mesh_pkt_pkg::pkt_w-1:0] req_pkt_i,
  input  wire logic                           req_valid_i,
  output logic                                req_ready_o,
  output logic      [mesh_pkt_pkg::pkt_w-1:0] rsp_pkt_o,
  output logic                                rsp_valid_o,
  input  wire logic                           rsp_ready_i
);

  localparam int DEPTH = 2 ** `MESH_ADDR_W;

  mesh_pkt_pkg::pkt_s  req;
  mesh_pkt_pkg::pkt_s  rsp_q;
  mesh_pkt_pkg::data_t mem [DEPTH];
  logic                rsp_valid_q;
  logic                accept;
  logic                is_load;

  assign req         = mesh_pkt_pkg::pkt_s'(req_pkt_i);
  assign req_ready_o = !rsp_valid_q || rsp_ready_i;
  assign accept      = req_valid_i && req_ready_o;
  assign is_load     = accept && req.opcode == mesh_pkt_pkg::OP_LOAD;

  // unwritten words read back as zero
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int i = 0; i < DEPTH; i++) begin
        mem[i] <= '0;
      end
    end else if (accept && req.opcode == mesh_pkt_pkg::OP_STORE) begin
      mem[req.addr] <= req.data;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rsp_valid_q <= 1'b0;
    end else if (is_load) begin
      rsp_valid_q <= 1'b1;
    end else if (rsp_ready_i) begin
      rsp_valid_q <= 1'b0;
    end
  end

  // reply heads back to the host at x = 0
  always_ff @(posedge clk_i) begin
    if (is_load) begin
      rsp_q.opcode <= mesh_pkt_pkg::OP_REPLY;
      rsp_q.dst_x  <= '0;
      rsp_q.src_x  <= my_x_i;
      rsp_q.addr   <= req.addr;
      rsp_q.data   <= mem[req.addr];
    end
  end

  assign rsp_pkt_o   = rsp_q;
  assign rsp_valid_o = rsp_valid_q;

  a_no_reply_in : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    req_valid_i |-> req.opcode != mesh_pkt_pkg::OP_REPLY);

endmodule

`default_nettype wire

//--- mesh_router.sv
// five-port x router with half ruche, one output register per port
// inputs compete per output through a round-robin arbiter
`timescale 1ns/1ps
`default_nettype none

`include "mesh_params.svh"

module mesh_router #(
  parameter int MY_X = 1
) (
  input  wire logic                                                    clk_i,
  input  wire logic                                                    arst_n_i,
  input  wire logic [mesh_dir_pkg::NUM_DIRS-1:0][mesh_pkt_pkg::pkt_w-1:0] link_pkt_i,
  input  wire logic [mesh_dir_pkg::NUM_DIRS-1:0]                       link_valid_i,
  output logic      [mesh_dir_pkg::NUM_DIRS-1:0]                       link_ready_o,
  output logic      [mesh_dir_pkg::NUM_DIRS-1:0][mesh_pkt_pkg::pkt_w-1:0] link_pkt_o,
  output logic      [mesh_dir_pkg::NUM_DIRS-1:0]                       link_valid_o,
  input  wire logic [mesh_dir_pkg::NUM_DIRS-1:0]                       link_ready_i
);

  localparam int ND    = mesh_dir_pkg::NUM_DIRS;
  localparam int PKT_W = mesh_pkt_pkg::pkt_w;

  // [input][output] and [output][input] views of the same requests
  logic [ND-1:0][ND-1:0]    route_oh;
  logic [ND-1:0][ND-1:0]    out_req;
  logic [ND-1:0][ND-1:0]    out_gnt;
  logic [ND-1:0]            can_load;
  logic [ND-1:0]            out_adv;
  logic [ND-1:0][PKT_W-1:0] sel_pkt;
  logic [ND-1:0][PKT_W-1:0] out_pkt_q;
  logic [ND-1:0]            out_valid_q;

  // dimension-ordered x route, ruche for long hops between tiles
  function automatic mesh_dir_pkg::dir_e route_of(mesh_pkt_pkg::x_cord_t dst);
    int dx;
    dx = int'(dst) - MY_X;
    if (dx == 0) begin
      return mesh_dir_pkg::DIR_P;
    end else if (dst != '0 && dx >= `MESH_RUCHE_FACTOR) begin
      return mesh_dir_pkg::DIR_RE;
    end else if (dst != '0 && dx <= -`MESH_RUCHE_FACTOR) begin
      return mesh_dir_pkg::DIR_RW;
    end else if (dx > 0) begin
      return mesh_dir_pkg::DIR_E;
    end
    return mesh_dir_pkg::DIR_W;
  endfunction

  always_comb begin : decode
    mesh_pkt_pkg::pkt_s pkt;
    route_oh = '0;
    for (int i = 0; i < ND; i++) begin
      pkt = mesh_pkt_pkg::pkt_s'(link_pkt_i[i]);
      route_oh[i][route_of(pkt.dst_x)] = link_valid_i[i];
    end
    for (int o = 0; o < ND; o++) begin
      for (int i = 0; i < ND; i++) begin
        out_req[o][i] = route_oh[i][o];
      end
    end
  end

  for (genvar o = 0; o < ND; o++) begin : g_out
    // register loads when empty or drained this cycle
    assign can_load[o] = !out_valid_q[o] || link_ready_i[o];
    assign out_adv[o]  = (|out_gnt[o]) && can_load[o];

    rr_arbiter i_arb (
      .clk_i     (clk_i),
      .arst_n_i  (arst_n_i),
      .req_i     (out_req[o]),
      .advance_i (out_adv[o]),
      .grant_o   (out_gnt[o])
    );
  end

  // each input routes to one output, so at most one grant per input
  always_comb begin
    link_ready_o = '0;
    sel_pkt      = '0;
    for (int o = 0; o < ND; o++) begin
      for (int i = 0; i < ND; i++) begin
        if (out_gnt[o][i]) begin
          sel_pkt[o]      = link_pkt_i[i];
          link_ready_o[i] = link_ready_o[i] | can_load[o];
        end
      end
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      out_valid_q <= '0;
    end else begin
      for (int o = 0; o < ND; o++) begin
        if (can_load[o]) begin
          out_valid_q[o] <= |out_gnt[o];
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    for (int o = 0; o < ND; o++) begin
      if (out_adv[o]) begin
        out_pkt_q[o] <= sel_pkt[o];
      end
    end
  end

  assign link_pkt_o   = out_pkt_q;
  assign link_valid_o = out_valid_q;

  // west of tile 1 is the host, only replies may leave there
  if (MY_X == 1) begin : g_host_edge
    mesh_pkt_pkg::pkt_s w_out_pkt;
    assign w_out_pkt = mesh_pkt_pkg::pkt_s'(out_pkt_q[mesh_dir_pkg::DIR_W]);

    a_host_only_replies : assert property (@(posedge clk_i) disable iff (!arst_n_i)
      link_valid_o[mesh_dir_pkg::DIR_W] |-> w_out_pkt.dst_x == '0);
  end

  // outputs that leave the row are tied off at the top level
  localparam logic [ND-1:0] EDGE_MASK =
    ((MY_X == `MESH_NUM_TILES) ? (1 << mesh_dir_pkg::DIR_E) : 0) |
    ((MY_X + `MESH_RUCHE_FACTOR > `MESH_NUM_TILES) ? (1 << mesh_dir_pkg::DIR_RE) : 0) |
    ((MY_X <= `MESH_RUCHE_FACTOR) ? (1 << mesh_dir_pkg::DIR_RW) : 0);

  a_edge_idle : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (link_valid_o & EDGE_MASK) == '0);

endmodule

`default_nettype wire

//--- rr_arbiter.sv
// round-robin arbiter across the five router input ports
// one instance per router output with the pointer moving only on a real transfer
`timescale 1ns/1ps
`default_nettype none

module rr_arbiter (
  input  wire logic                              clk_i,
  input  wire logic                              arst_n_i,
  input  wire logic [mesh_dir_pkg::NUM_DIRS-1:0] req_i,
  input  wire logic                              advance_i,
  output logic      [mesh_dir_pkg::NUM_DIRS-1:0] grant_o
);

  mesh_dir_pkg::dir_e ptr_q;
  int                 gnt_idx;

  // first requester at or after the pointer
  always_comb begin : pick
    int idx;
    grant_o = '0;
    gnt_idx = 0;
    for (int i = mesh_dir_pkg::NUM_DIRS - 1; i >= 0; i--) begin
      idx = (int'(ptr_q) + i) % mesh_dir_pkg::NUM_DIRS;
      if (req_i[idx]) begin
        gnt_idx = idx;
      end
    end
    grant_o[gnt_idx] = req_i[gnt_idx];
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ptr_q <= mesh_dir_pkg::DIR_P;
    end else if (advance_i) begin
      ptr_q <= mesh_dir_pkg::dir_e'((gnt_idx + 1) % mesh_dir_pkg::NUM_DIRS);
    end
  end

  // a port that just transferred yields to any other waiting port
  a_grant_rotates : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    advance_i |=> ((req_i & ~$past(grant_o)) == '0) || ((grant_o & $past(grant_o)) == '0));

endmodule

`default_nettype wire

//--- mesh_dir_pkg.sv
// router port directions, used to index the packed link vectors
`default_nettype none

package mesh_dir_pkg;

  // P is the local endpoint, R* are the ruche ports
  typedef enum logic [2:0] {
    DIR_P  = 3'd0,
    DIR_W  = 3'd1,
    DIR_E  = 3'd2,
    DIR_RW = 3'd3,
    DIR_RE = 3'd4
  } dir_e;

  localparam int NUM_DIRS = 5;

endpackage

`default_nettype wire

//--- mesh_pkt_pkg.sv
// packet opcodes and field types for the tile network
// referenced by scoped name from router, endpoint and top level
`default_nettype none

`include "mesh_params.svh"

package mesh_pkt_pkg;

  typedef enum logic [1:0] {
    OP_STORE = 2'd0,
    OP_LOAD  = 2'd1,
    OP_REPLY = 2'd2
  } opcode_e;

  typedef logic [`MESH_X_W-1:0]    x_cord_t;
  typedef logic [`MESH_ADDR_W-1:0] addr_t;
  typedef logic [`MESH_DATA_W-1:0] data_t;

  // field order from msb down
  typedef struct packed {
    opcode_e opcode;
    x_cord_t dst_x;
    x_cord_t src_x;
    addr_t   addr;
    data_t   data;
  } pkt_s;

  // flat width carried on every link
  localparam int pkt_w = $bits(pkt_s);

endpackage

`default_nettype wire

//--- mesh_params.svh
// sizing macros for the ruche tile row
// include wherever tile count, ruche distance or field widths are needed
`ifndef MESH_PARAMS_SVH
`define MESH_PARAMS_SVH

// tiles in the row, host sits at x = 0
`define MESH_NUM_TILES 4

// tile distance spanned by one ruche hop
`define MESH_RUCHE_FACTOR 2

// packet field widths
`define MESH_X_W 3
`define MESH_ADDR_W 4
`define MESH_DATA_W 16

`endif
